/* source/lsu_config.svh */
// --------------------
// Width, RAM depth and RAM reply delay of the lsu
// --------------------
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN      32

// RAM depth in words, indexed from address bit 2 upward
`define LSU_RAM_WORDS 64

// Cycles from req seen to ack raised
`define LSU_RAM_DELAY 2

`endif

/* source/lsu_pkg.sv */
// --------------------
// Result routes, funct3 codes, load opcode, controller states
// --------------------
`default_nettype none

package lsu_pkg;

    // Where the stage sends its result
    typedef enum logic [1:0] {
        RES_NONE = 2'd0,
        RES_REG  = 2'd1,
        RES_MEM  = 2'd2,
        RES_CSR  = 2'd3
    } res_op_e;

    // Load and store widths, stores reuse B/H/W
    localparam logic [2:0] F3_B      = 3'b000;
    localparam logic [2:0] F3_H      = 3'b001;
    localparam logic [2:0] F3_W      = 3'b010;
    localparam logic [2:0] F3_BU     = 3'b100;
    localparam logic [2:0] F3_HU     = 3'b101;

    // CSR source select
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRWI = 3'b101;

    localparam logic [6:0] OPC_LOAD  = 7'b000_0011;

    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_RD_REQ = 3'd1,
        ST_RD_REL = 3'd2,
        ST_WR_REQ = 3'd3,
        ST_WR_REL = 3'd4,
        ST_CAP    = 3'd5,
        ST_ACK    = 3'd6
    } ctrl_state_e;

endpackage

`default_nettype wire

/* source/mem_if.sv */
// --------------------
// Four-phase req/ack bus to the data RAM
// --------------------
`default_nettype none
`include "lsu_config.svh"

interface mem_if;
    logic                 req;
    logic                 we;
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] wdata;
    logic [`LSU_XLEN-1:0] rdata;
    logic                 ack;

    // Handshake side of the controller
    modport ctrl (output req, output we, input ack);

    // Address and data paths
    modport dp (output addr, output wdata, input rdata);

    modport ram (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );
endinterface

`default_nettype wire

/* source/access_ctrl.sv */
// --------------------
// Control FSM for the operation and RAM handshakes
// --------------------
`default_nettype none
`include "lsu_config.svh"

module access_ctrl (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       op_req_i,
    output logic                      op_ack_o,
    input  wire lsu_pkg::res_op_e     res_op_i,
    input  wire [2:0]                 funct3_i,
    input  wire [6:0]                 opcode_i,
    mem_if.ctrl                       mem,
    input  wire [`LSU_XLEN-1:0]       rdata_i,
    output logic [`LSU_XLEN-1:0]      old_word_o,
    output logic                      cap_o,
    output lsu_pkg::ctrl_state_e      state_o
);
    import lsu_pkg::*;

    ctrl_state_e          state_q;
    ctrl_state_e          state_d;
    logic                 is_load;
    logic                 need_rd;
    logic                 need_wr;
    logic [`LSU_XLEN-1:0] rd_word_q;

    // Loads hide under RES_REG, marked by the opcode
    assign is_load = (res_op_i == RES_REG) && (opcode_i == OPC_LOAD);
    assign need_rd = is_load || (res_op_i == RES_MEM);
    // Only real store widths write back
    assign need_wr = (res_op_i == RES_MEM) &&
                     (funct3_i == F3_B || funct3_i == F3_H || funct3_i == F3_W);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (op_req_i) state_d = need_rd ? ST_RD_REQ : ST_CAP;
            ST_RD_REQ: if (mem.ack) state_d = ST_RD_REL;
            ST_RD_REL: if (!mem.ack) state_d = need_wr ? ST_WR_REQ : ST_CAP;
            ST_WR_REQ: if (mem.ack) state_d = ST_WR_REL;
            ST_WR_REL: if (!mem.ack) state_d = ST_CAP;
            ST_CAP:    state_d = ST_ACK;
            // Hold the ack until the requester lets go
            ST_ACK:    if (!op_req_i) state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Read word, taken while the RAM holds ack
    always_ff @(posedge clk) begin
        if (state_q == ST_RD_REQ && mem.ack) begin
            rd_word_q <= rdata_i;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    assign mem.req    = (state_q == ST_RD_REQ) || (state_q == ST_WR_REQ);
    assign mem.we     = (state_q == ST_WR_REQ);
    assign cap_o      = (state_q == ST_CAP);
    assign op_ack_o   = (state_q == ST_ACK);
    assign old_word_o = rd_word_q;
    assign state_o    = state_q;

endmodule

`default_nettype wire

/* source/store_merge.sv */
// --------------------
// Byte, halfword or word merge of store data
// --------------------
`default_nettype none
`include "lsu_config.svh"

module store_merge (
    input  wire [`LSU_XLEN-1:0]  old_word_i,
    input  wire [`LSU_XLEN-1:0]  rs2_data_i,
    input  wire [2:0]            funct3_i,
    input  wire [1:0]            byte_off_i,
    output logic [`LSU_XLEN-1:0] wdata_o
);
    import lsu_pkg::*;

    always_comb begin
        // Lanes not written keep the old word
        wdata_o = old_word_i;
        case (funct3_i)
            F3_B: wdata_o[{byte_off_i, 3'b000} +: 8] = rs2_data_i[7:0];
            // Halfword picked by offset bit 1 only
            F3_H: wdata_o[{byte_off_i[1], 4'b0000} +: 16] = rs2_data_i[15:0];
            F3_W: wdata_o = rs2_data_i;
            default: wdata_o = old_word_i;
        endcase
    end

endmodule

`default_nettype wire

/* source/load_extract.sv */
// --------------------
// Load lane select with sign or zero extension
// --------------------
`default_nettype none
`include "lsu_config.svh"

module load_extract (
    input  wire [`LSU_XLEN-1:0]  word_i,
    input  wire [2:0]            funct3_i,
    input  wire [1:0]            byte_off_i,
    output logic [`LSU_XLEN-1:0] load_data_o
);
    import lsu_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // Same lane rule as the store merge
    assign lane_b = word_i[{byte_off_i, 3'b000} +: 8];
    assign lane_h = word_i[{byte_off_i[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3_i)
            F3_B:    load_data_o = {{(`LSU_XLEN - 8){lane_b[7]}}, lane_b};
            F3_H:    load_data_o = {{(`LSU_XLEN - 16){lane_h[15]}}, lane_h};
            F3_W:    load_data_o = word_i;
            F3_BU:   load_data_o = {{(`LSU_XLEN - 8){1'b0}}, lane_b};
            F3_HU:   load_data_o = {{(`LSU_XLEN - 16){1'b0}}, lane_h};
            // Unknown width reads as zero
            default: load_data_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/wb_route.sv */
// --------------------
// Register and CSR write data selection and hold
// --------------------
`default_nettype none
`include "lsu_config.svh"

module wb_route (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cap_i,
    input  wire lsu_pkg::res_op_e  res_op_i,
    input  wire [2:0]              funct3_i,
    input  wire [6:0]              opcode_i,
    input  wire [`LSU_XLEN-1:0]    rs1_data_i,
    input  wire [`LSU_XLEN-1:0]    imm_i,
    input  wire [`LSU_XLEN-1:0]    alu_res_i,
    input  wire [`LSU_XLEN-1:0]    csr_rd_data_i,
    input  wire [`LSU_XLEN-1:0]    load_data_i,
    output logic [`LSU_XLEN-1:0]   reg_wr_data_o,
    output logic [`LSU_XLEN-1:0]   csr_wr_data_o
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] reg_sel;
    logic [`LSU_XLEN-1:0] csr_sel;

    always_comb begin
        case (res_op_i)
            RES_REG: reg_sel = (opcode_i == OPC_LOAD) ? load_data_i : alu_res_i;
            // Old CSR value goes back to the register file
            RES_CSR: reg_sel = csr_rd_data_i;
            default: reg_sel = '0;
        endcase
    end

    always_comb begin
        case (funct3_i)
            F3_CSRRW:  csr_sel = rs1_data_i;
            F3_CSRRWI: csr_sel = imm_i;
            default:   csr_sel = alu_res_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr_data_o <= '0;
            csr_wr_data_o <= '0;
        end else if (cap_i) begin
            reg_wr_data_o <= reg_sel;
            if (res_op_i == RES_CSR) begin
                csr_wr_data_o <= csr_sel;
            end
        end
    end

endmodule

`default_nettype wire

/* source/data_ram.sv */
// --------------------
// Word-addressed data RAM, four-phase reply after a fixed delay
// --------------------
`default_nettype none
`include "lsu_config.svh"

module data_ram (
    input wire clk,
    input wire rst_n,
    mem_if.ram mem
);
    localparam int delay = `LSU_RAM_DELAY;
    localparam int idx_w = $clog2(`LSU_RAM_WORDS);
    localparam int cnt_w = $clog2(delay + 1);

    logic [`LSU_XLEN-1:0]      mem_q [`LSU_RAM_WORDS];
    logic [`LSU_RAM_WORDS-1:0] valid_q;
    logic [`LSU_XLEN-1:0]      rdata_q;
    logic [cnt_w-1:0]          cnt_q;
    logic                      ack_q;
    logic [idx_w-1:0]          idx;
    logic                      fire;

    // Word index wraps at the RAM depth
    assign idx  = mem.addr[idx_w+1:2];
    assign fire = mem.req && !ack_q && (cnt_q == cnt_w'(delay - 1));

    // --------------------
    // Handshake and valid bits
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q   <= '0;
            ack_q   <= 1'b0;
            valid_q <= '0;
        end else if (!mem.req) begin
            cnt_q <= '0;
            ack_q <= 1'b0;
        end else if (fire) begin
            ack_q <= 1'b1;
            if (mem.we) begin
                valid_q[idx] <= 1'b1;
            end
        end else if (!ack_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Storage, write lands on the ack edge
    always_ff @(posedge clk) begin
        if (fire && mem.we) begin
            mem_q[idx] <= mem.wdata;
        end
        if (fire) begin
            rdata_q <= valid_q[idx] ? mem_q[idx] : '0;
        end
    end

    assign mem.ack   = ack_q;
    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

/* source/lsu_top.sv */
// --------------------
// lsu top level, controller plus datapath plus data RAM
// --------------------
`default_nettype none
`include "lsu_config.svh"

module lsu_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    op_req_i,
    output logic                   op_ack_o,
    input  wire lsu_pkg::res_op_e  res_op_i,
    input  wire [2:0]              funct3_i,
    input  wire [6:0]              opcode_i,
    input  wire [`LSU_XLEN-1:0]    rs1_data_i,
    input  wire [`LSU_XLEN-1:0]    rs2_data_i,
    input  wire [`LSU_XLEN-1:0]    imm_i,
    input  wire [`LSU_XLEN-1:0]    alu_res_i,
    input  wire [`LSU_XLEN-1:0]    csr_rd_data_i,
    output logic [`LSU_XLEN-1:0]   reg_wr_data_o,
    output logic [`LSU_XLEN-1:0]   csr_wr_data_o
);
    mem_if mem_bus ();

    logic [`LSU_XLEN-1:0] old_word;
    logic [`LSU_XLEN-1:0] merge_word;
    logic [`LSU_XLEN-1:0] load_data;
    logic [1:0]           byte_off;
    logic                 cap;
    lsu_pkg::ctrl_state_e ctrl_state;

    // ALU result is the effective address
    assign mem_bus.addr  = alu_res_i;
    assign mem_bus.wdata = merge_word;
    assign byte_off      = alu_res_i[1:0];

    access_ctrl u_access_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .op_req_i   (op_req_i),
        .op_ack_o   (op_ack_o),
        .res_op_i   (res_op_i),
        .funct3_i   (funct3_i),
        .opcode_i   (opcode_i),
        .mem        (mem_bus.ctrl),
        .rdata_i    (mem_bus.rdata),
        .old_word_o (old_word),
        .cap_o      (cap),
        .state_o    (ctrl_state)
    );

    store_merge u_store_merge (
        .old_word_i (old_word),
        .rs2_data_i (rs2_data_i),
        .funct3_i   (funct3_i),
        .byte_off_i (byte_off),
        .wdata_o    (merge_word)
    );

    load_extract u_load_extract (
        .word_i      (old_word),
        .funct3_i    (funct3_i),
        .byte_off_i  (byte_off),
        .load_data_o (load_data)
    );

    wb_route u_wb_route (
        .clk           (clk),
        .rst_n         (rst_n),
        .cap_i         (cap),
        .res_op_i      (res_op_i),
        .funct3_i      (funct3_i),
        .opcode_i      (opcode_i),
        .rs1_data_i    (rs1_data_i),
        .imm_i         (imm_i),
        .alu_res_i     (alu_res_i),
        .csr_rd_data_i (csr_rd_data_i),
        .load_data_i   (load_data),
        .reg_wr_data_o (reg_wr_data_o),
        .csr_wr_data_o (csr_wr_data_o)
    );

    data_ram u_data_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem_bus.ram)
    );

endmodule

`default_nettype wire

/* dv/lsu_checker.sv */
// --------------------
// Handshake assertions bound into lsu_top
// --------------------
`default_nettype none

module lsu_checker (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       op_req_i,
    input wire                       op_ack_i,
    input wire                       mem_req_i,
    input wire                       mem_we_i,
    input wire                       mem_ack_i,
    input wire lsu_pkg::ctrl_state_e state_i
);
    import lsu_pkg::*;

    // Failed assertions so far
    int fails = 0;

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(op_ack_i) |-> $past(op_req_i))
        else begin
            $error("op_ack_o rose without a pending op_req_i");
            fails++;
        end

    ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(op_ack_i) |-> !$past(op_req_i))
        else begin
            $error("op_ack_o fell while op_req_i was still high");
            fails++;
        end

    // RAM bus quiet and fully released while the FSM waits
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state_i == ST_IDLE) |-> (!mem_req_i && !mem_we_i && !mem_ack_i))
        else begin
            $error("RAM req, we or ack high in IDLE");
            fails++;
        end

    // Ack may trail req by one cycle on release
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack_i |-> (mem_req_i || $past(mem_req_i)))
        else begin
            $error("RAM ack high without a request");
            fails++;
        end

endmodule

bind lsu_top lsu_checker u_lsu_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_req_i  (op_req_i),
    .op_ack_i  (op_ack_o),
    .mem_req_i (mem_bus.req),
    .mem_we_i  (mem_bus.we),
    .mem_ack_i (mem_bus.ack),
    .state_i   (ctrl_state)
);

`default_nettype wire

/* dv/lsu_tb.sv */
// --------------------
// lsu testbench with LFSR stimulus and a reference word model
// --------------------
`default_nettype none
`include "lsu_config.svh"

module lsu_tb;
    import lsu_pkg::*;

    localparam int n_ops     = 132;
    // Read and write RAM phases plus control overhead
    localparam int op_cycles = 4 * (`LSU_RAM_DELAY + 2) + 24;
    localparam logic [6:0] opc_store  = 7'b010_0011;
    localparam logic [6:0] opc_op     = 7'b011_0011;
    localparam logic [6:0] opc_system = 7'b111_0011;

    logic                 clk;
    logic                 rst_n;
    logic                 op_req_i;
    logic                 op_ack_o;
    res_op_e              res_op_i;
    logic [2:0]           funct3_i;
    logic [6:0]           opcode_i;
    logic [`LSU_XLEN-1:0] rs1_data_i;
    logic [`LSU_XLEN-1:0] rs2_data_i;
    logic [`LSU_XLEN-1:0] imm_i;
    logic [`LSU_XLEN-1:0] alu_res_i;
    logic [`LSU_XLEN-1:0] csr_rd_data_i;
    logic [`LSU_XLEN-1:0] reg_wr_data_o;
    logic [`LSU_XLEN-1:0] csr_wr_data_o;

    logic [`LSU_XLEN-1:0] ref_mem [`LSU_RAM_WORDS];
    logic [`LSU_XLEN-1:0] exp_csr;
    logic [31:0]          lfsr;
    logic [31:0]          addr;
    logic [31:0]          data;
    logic [2:0]           ext_f3 [4] = '{F3_B, F3_BU, F3_H, F3_HU};
    logic [2:0]           csr_f3 [3] = '{F3_CSRRW, F3_CSRRWI, 3'b010};
    int                   errors   = 0;
    int                   timeouts = 0;
    int                   cycles   = 0;

    lsu_top u_lsu_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [31:0] merge_ref(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [2:0] f3, input logic [1:0] off);
        logic [31:0] mask;
        logic [31:0] rep;
        mask = (f3 == F3_W) ? 32'hffff_ffff :
               (f3 == F3_H) ? (32'h0000_ffff << (off[1] * 16)) : (32'h0000_00ff << (off * 8));
        rep  = (f3 == F3_W) ? wd : (f3 == F3_H) ? {2{wd[15:0]}} : {4{wd[7:0]}};
        return (old & ~mask) | (rep & mask);
    endfunction

    function automatic logic [31:0] extract_ref(input logic [31:0] w, input logic [2:0] f3,
                                                input logic [1:0] off);
        logic [31:0] sh;
        sh = (f3 == F3_H || f3 == F3_HU) ? (w >> (off[1] * 16)) : (w >> (off * 8));
        case (f3)
            F3_B:    return {{24{sh[7]}}, sh[7:0]};
            F3_BU:   return {24'h0, sh[7:0]};
            F3_H:    return {{16{sh[15]}}, sh[15:0]};
            F3_HU:   return {16'h0, sh[15:0]};
            F3_W:    return w;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Full four-phase operation, results checked while op_ack_o is high
    task automatic run_op(input res_op_e res, input logic [2:0] f3, input logic [6:0] opc,
                          input logic [31:0] alu, input logic [31:0] rs2);
        logic [31:0] exp_reg;
        logic [31:0] v;
        int          idx;
        idx = (alu >> 2) % `LSU_RAM_WORDS;
        @(posedge clk);
        #1;
        check_value("op_ack_o", 32'h0, {31'h0, op_ack_o});
        res_op_i   = res;
        funct3_i   = f3;
        opcode_i   = opc;
        alu_res_i  = alu;
        rs2_data_i = rs2;
        take_bits(32, v);
        rs1_data_i = v;
        take_bits(32, v);
        imm_i = v;
        take_bits(32, v);
        csr_rd_data_i = v;
        op_req_i = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!op_ack_o);
        case (res)
            RES_REG: exp_reg = (opc == OPC_LOAD) ? extract_ref(ref_mem[idx], f3, alu[1:0]) : alu;
            RES_CSR: exp_reg = csr_rd_data_i;
            default: exp_reg = '0;
        endcase
        if (res == RES_CSR) begin
            exp_csr = (f3 == F3_CSRRW) ? rs1_data_i : (f3 == F3_CSRRWI) ? imm_i : alu;
        end
        if (res == RES_MEM) begin
            ref_mem[idx] = merge_ref(ref_mem[idx], rs2, f3, alu[1:0]);
        end
        check_value("reg_wr_data_o", exp_reg, reg_wr_data_o);
        check_value("csr_wr_data_o", exp_csr, csr_wr_data_o);
        op_req_i = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (op_ack_o);
    endtask

    task automatic finish_run();
        errors += u_lsu_top.u_lsu_checker.fails;
        $display("Errors: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        lfsr          = 32'ha1d0_ea59;
        rst_n         = 1'b0;
        op_req_i      = 1'b0;
        res_op_i      = RES_NONE;
        funct3_i      = '0;
        opcode_i      = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        imm_i         = '0;
        alu_res_i     = '0;
        csr_rd_data_i = '0;
        exp_csr       = '0;
        foreach (ref_mem[i]) ref_mem[i] = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_value("op_ack_o", 32'h0, {31'h0, op_ack_o});
        check_value("reg_wr_data_o", 32'h0, reg_wr_data_o);

        // Word store, then word load from the same address
        repeat (8) begin
            take_bits(32, addr);
            take_bits(32, data);
            run_op(RES_MEM, F3_W, opc_store, addr, data);
            run_op(RES_REG, F3_W, OPC_LOAD, addr, '0);
        end

        // Byte at every offset, halfword at 0 and 2, each read back whole
        repeat (2) begin
            take_bits(32, addr);
            for (int off = 0; off < 4; off++) begin
                take_bits(32, data);
                run_op(RES_MEM, F3_B, opc_store, {addr[31:2], off[1:0]}, data);
                run_op(RES_REG, F3_W, OPC_LOAD, addr, '0);
            end
            for (int off = 0; off < 4; off += 2) begin
                take_bits(32, data);
                run_op(RES_MEM, F3_H, opc_store, {addr[31:2], off[1:0]}, data);
                run_op(RES_REG, F3_W, OPC_LOAD, addr, '0);
            end
        end

        // Sign and zero extension on random words
        repeat (4) begin
            take_bits(32, addr);
            take_bits(32, data);
            run_op(RES_MEM, F3_W, opc_store, addr, data);
            for (int off = 0; off < 4; off++) begin
                foreach (ext_f3[k]) begin
                    run_op(RES_REG, ext_f3[k], OPC_LOAD, {addr[31:2], off[1:0]}, '0);
                end
            end
        end

        // CSR routing by funct3
        repeat (4) begin
            foreach (csr_f3[k]) begin
                take_bits(32, addr);
                run_op(RES_CSR, csr_f3[k], opc_system, addr, '0);
            end
        end

        // Pass-through and none, CSR data must hold
        repeat (4) begin
            take_bits(32, addr);
            run_op(RES_REG, F3_W, opc_op, addr, '0);
            take_bits(32, addr);
            run_op(RES_REG, F3_B, opc_op, addr, '0);
            take_bits(32, addr);
            run_op(RES_NONE, F3_W, opc_op, addr, '0);
        end
        finish_run();
    end

    initial begin
        while (cycles < n_ops * op_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycles);
        timeouts++;
        finish_run();
    end

endmodule

`default_nettype wire

/* lsu.f */
+incdir+source
source/lsu_pkg.sv
source/mem_if.sv
source/access_ctrl.sv
source/store_merge.sv
source/load_extract.sv
source/wb_route.sv
source/data_ram.sv
source/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv
